/* list.f */
+incdir+common
common/aes_types_pkg.sv
common/aes_tables_pkg.sv
design/aes_sbox_column.sv
design/key_expand/aes_key_round.sv
design/cipher/aes_mix_round.sv
design/cipher/aes_final_round.sv
design/aes_128.sv
verif/aes_checker.sv
verif/aes_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = aes_tb
FILELIST  = list.f
OBJ_DIR   = obj_dir
PASS_MSG  = Regression passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run the regression"
	@echo "  clean  remove the build directory"

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST) | grep -v '^+')
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only if the pass line shows up in the simulation output.
test: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)

/* verif/aes_tb.sv */
`timescale 1ns/100ps
`include "aes_defines.svh"

module aes_tb;

  localparam aes_types_pkg::block_t KV_KEY = 128'h000102030405060708090a0b0c0d0e0f;
  localparam aes_types_pkg::block_t KV_PT  = 128'h00112233445566778899aabbccddeeff;
  localparam aes_types_pkg::block_t KV_CT  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;

  logic                  clk;
  logic                  rst;
  logic                  in_valid;
  aes_types_pkg::block_t state;
  aes_types_pkg::block_t key;
  logic                  out_valid;
  aes_types_pkg::block_t out;

  // outstanding blocks, oldest first, with the edge that sampled them.
  aes_types_pkg::block_t exp_q [$];
  string                 name_q [$];
  int                    cyc_q [$];

  int    cycle = 0;
  int    errors = 0;
  int    checks = 0;
  int    tests_run = 0;
  int    tests_failed = 0;
  int    test_start_err;
  bit    timed_out = 1'b0;
  string cur_test;

  aes_128 UUT (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .state     (state),
    .key       (key),
    .out_valid (out_valid),
    .out       (out)
  );

  always #4 clk = ~clk;

  always @(posedge clk)
  begin
    cycle <= cycle + 1;
  end

  // cipher worked step by step on a byte array.
  // byte 4c+r is row r of column c, byte 0 in the top bits.
  function automatic aes_types_pkg::block_t aes_ref(
    input aes_types_pkg::block_t pt,
    input aes_types_pkg::block_t k
  );
    aes_types_pkg::byte_t  s [16];
    aes_types_pkg::byte_t  t [16];
    aes_types_pkg::byte_t  rk [16];
    aes_types_pkg::byte_t  tmp [4];
    aes_types_pkg::byte_t  a [4];
    aes_types_pkg::byte_t  rc;
    aes_types_pkg::block_t res;
    for (int i = 0; i < 16; i++)
    begin
      rk[i] = k[`AES_BLOCK_W-1-8*i -: 8];
      s[i]  = pt[`AES_BLOCK_W-1-8*i -: 8] ^ rk[i];
    end
    rc = 8'h01;
    for (int round = 1; round <= `AES_ROUNDS; round++)
    begin
      // rotword and subword of the last key word, then rcon.
      tmp[0] = aes_tables_pkg::SBOX[rk[13]] ^ rc;
      tmp[1] = aes_tables_pkg::SBOX[rk[14]];
      tmp[2] = aes_tables_pkg::SBOX[rk[15]];
      tmp[3] = aes_tables_pkg::SBOX[rk[12]];
      for (int r = 0; r < 4; r++)
      begin
        rk[r] = rk[r] ^ tmp[r];
      end
      for (int i = 4; i < 16; i++)
      begin
        rk[i] = rk[i] ^ rk[i-4];
      end
      rc = aes_tables_pkg::xtime(rc);
      // subbytes and shiftrows together.
      for (int c = 0; c < 4; c++)
      begin
        for (int r = 0; r < 4; r++)
        begin
          t[4*c+r] = aes_tables_pkg::SBOX[s[4*((c+r)%4)+r]];
        end
      end
      for (int c = 0; c < 4; c++)
      begin
        for (int r = 0; r < 4; r++)
        begin
          a[r] = t[4*c+r];
        end
        if (round < `AES_ROUNDS)
        begin
          s[4*c]   = aes_tables_pkg::xtime(a[0] ^ a[1]) ^ a[1] ^ a[2] ^ a[3];
          s[4*c+1] = aes_tables_pkg::xtime(a[1] ^ a[2]) ^ a[2] ^ a[3] ^ a[0];
          s[4*c+2] = aes_tables_pkg::xtime(a[2] ^ a[3]) ^ a[3] ^ a[0] ^ a[1];
          s[4*c+3] = aes_tables_pkg::xtime(a[3] ^ a[0]) ^ a[0] ^ a[1] ^ a[2];
        end
        else
        begin
          for (int r = 0; r < 4; r++)
          begin
            s[4*c+r] = a[r];
          end
        end
        for (int r = 0; r < 4; r++)
        begin
          s[4*c+r] = s[4*c+r] ^ rk[4*c+r];
        end
      end
    end
    for (int i = 0; i < 16; i++)
    begin
      res[`AES_BLOCK_W-1-8*i -: 8] = s[i];
    end
    return res;
  endfunction

  function automatic aes_types_pkg::block_t rand_block();
    return {$urandom, $urandom, $urandom, $urandom};
  endfunction

  task automatic start_test(input string name);
    cur_test       = name;
    test_start_err = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors == test_start_err)
    begin
      $display("%s: ok", cur_test);
    end
    else
    begin
      tests_failed++;
      $display("%s: %0d errors", cur_test, errors - test_start_err);
    end
  endtask

  // the DUT samples these at the next edge, number cycle + 1.
  task automatic send_block(
    input aes_types_pkg::block_t pt,
    input aes_types_pkg::block_t k,
    input aes_types_pkg::block_t expected
  );
    @(posedge clk);
    #1;
    in_valid = 1'b1;
    state    = pt;
    key      = k;
    exp_q.push_back(expected);
    name_q.push_back(cur_test);
    cyc_q.push_back(cycle + 1);
  endtask

  task automatic send_idle();
    @(posedge clk);
    #1;
    in_valid = 1'b0;
    state    = rand_block();
    key      = rand_block();
  endtask

  task automatic wait_drain(input int limit);
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < limit)
    begin
      @(posedge clk);
      n++;
    end
    if (exp_q.size() != 0)
    begin
      $display("Timeout: %0d blocks never came out within %0d cycles", exp_q.size(), limit);
      errors++;
      timed_out = 1'b1;
    end
  endtask

  task automatic check_quiet();
    checks++;
    assert (out_valid === 1'b0)
    else
    begin
      $display("Fail %s: expected out_valid 0, actual %b", cur_test, out_valid);
      errors++;
    end
  endtask

  task automatic reset_quiet();
    aes_types_pkg::block_t pt;
    aes_types_pkg::block_t k;
    start_test("reset_quiet");
    for (int i = 0; i < 5; i++)
    begin
      @(posedge clk);
      #1;
      check_quiet();
    end
    rst = 1'b0;
    // the first block must not show up before its full latency.
    pt = rand_block();
    k  = rand_block();
    send_block(pt, k, aes_ref(pt, k));
    send_idle();
    check_quiet();
    for (int i = 0; i < `AES_LATENCY - 2; i++)
    begin
      @(posedge clk);
      #1;
      check_quiet();
    end
    wait_drain(4 * `AES_LATENCY);
    end_test();
  endtask

  task automatic known_vector();
    start_test("known_vector");
    checks++;
    assert (aes_ref(KV_PT, KV_KEY) === KV_CT)
    else
    begin
      $display("Fail %s model: expected %h, actual %h", cur_test, KV_CT, aes_ref(KV_PT, KV_KEY));
      errors++;
    end
    send_block(KV_PT, KV_KEY, KV_CT);
    send_idle();
    wait_drain(4 * `AES_LATENCY);
    end_test();
  endtask

  task automatic fixed_latency();
    aes_types_pkg::block_t pt;
    aes_types_pkg::block_t k;
    start_test("fixed_latency");
    pt = rand_block();
    k  = rand_block();
    send_block(pt, k, aes_ref(pt, k));
    send_idle();
    wait_drain(4 * `AES_LATENCY);
    end_test();
  endtask

  task automatic back_to_back();
    aes_types_pkg::block_t pt;
    aes_types_pkg::block_t k;
    start_test("back_to_back");
    for (int i = 0; i < 40; i++)
    begin
      pt = rand_block();
      k  = rand_block();
      send_block(pt, k, aes_ref(pt, k));
    end
    send_idle();
    wait_drain(40 + 4 * `AES_LATENCY);
    end_test();
  endtask

  task automatic random_gaps();
    aes_types_pkg::block_t pt;
    aes_types_pkg::block_t k;
    start_test("random_gaps");
    for (int i = 0; i < 80; i++)
    begin
      pt = rand_block();
      k  = rand_block();
      if ($urandom % 2 == 1)
      begin
        send_block(pt, k, aes_ref(pt, k));
      end
      else
      begin
        send_idle();
      end
    end
    send_idle();
    wait_drain(80 + 4 * `AES_LATENCY);
    end_test();
  endtask

  // every output block is matched against the oldest outstanding one.
  initial
  begin
    aes_types_pkg::block_t expected;
    string                 name;
    int                    k;
    forever
    begin
      @(negedge clk);
      if (out_valid === 1'b1)
      begin
        checks++;
        assert (exp_q.size() != 0)
        else
        begin
          $display("Error: out_valid is high with no block outstanding at cycle %0d", cycle);
          errors++;
        end
        if (exp_q.size() != 0)
        begin
          expected = exp_q.pop_front();
          name     = name_q.pop_front();
          k        = cyc_q.pop_front();
          assert (out === expected)
          else
          begin
            $display("Fail %s: expected %h, actual %h", name, expected, out);
            errors++;
          end
          // a consumer takes the block at the next edge.
          assert (cycle + 1 - k == `AES_LATENCY)
          else
          begin
            $display("Fail %s latency: expected %0d, actual %0d", name, `AES_LATENCY,
                     cycle + 1 - k);
            errors++;
          end
        end
      end
    end
  end

  initial
  begin
    clk      = 1'b0;
    rst      = 1'b1;
    in_valid = 1'b0;
    state    = '0;
    key      = '0;
    void'($urandom(32'ha6dd_b514));
    reset_quiet();
    if (!timed_out)
    begin
      known_vector();
    end
    if (!timed_out)
    begin
      fixed_latency();
    end
    if (!timed_out)
    begin
      back_to_back();
    end
    if (!timed_out)
    begin
      random_gaps();
    end
    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0)
    begin
      $display("Regression passed");
    end
    else
    begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* verif/aes_checker.sv */
`timescale 1ns/100ps
`include "aes_defines.svh"

module aes_checker (
  input logic                  clk,
  input logic                  rst,
  input logic                  in_valid,
  input logic                  out_valid,
  input aes_types_pkg::block_t out
);

  // cycles since reset fell, held at the pipeline depth.
  int unsigned quiet_cnt;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      quiet_cnt <= 0;
    end
    else if (quiet_cnt < `AES_LATENCY)
    begin
      quiet_cnt <= quiet_cnt + 1;
    end
  end

  valid_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(out_valid))
    else $error("out_valid is unknown");

  // the delay line is full of real history only once reset has been low long enough.
  valid_delay: assert property (@(posedge clk) disable iff (rst)
    (quiet_cnt == `AES_LATENCY) |-> (out_valid == $past(in_valid, `AES_LATENCY)))
    else $error("out_valid does not follow in_valid by the pipeline latency");

  out_known: assert property (@(posedge clk) disable iff (rst) out_valid |-> !$isunknown(out))
    else $error("out has unknown bits while out_valid is high");

endmodule

bind aes_128 aes_checker u_checker (
  .clk       (clk),
  .rst       (rst),
  .in_valid  (in_valid),
  .out_valid (out_valid),
  .out       (out)
);

/* design/aes_128.sv */
`timescale 1ns/100ps
`include "aes_defines.svh"

module aes_128 (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  in_valid,
  input  aes_types_pkg::block_t state,
  input  aes_types_pkg::block_t key,
  output logic                  out_valid,
  output aes_types_pkg::block_t out
);

  // key_chain[i] and st[i] enter key stage i and cipher round i together.
  aes_types_pkg::block_t  key_chain [`AES_ROUNDS];
  aes_types_pkg::block_t  rkey [`AES_ROUNDS];
  aes_types_pkg::block_t  st [`AES_ROUNDS];
  logic [`AES_LATENCY-1:0] valid_sr;

  // initial addroundkey.
  always_ff @(posedge clk)
  begin
    st[0]        <= state ^ key;
    key_chain[0] <= key;
  end

  for (genvar i = 0; i < `AES_ROUNDS; i++)
  begin : g_key
    if (i < `AES_ROUNDS - 1)
    begin : g_mid
      aes_key_round u_key (
        .clk       (clk),
        .key_in    (key_chain[i]),
        .rcon      (aes_tables_pkg::RCON[i]),
        .round_key (rkey[i]),
        .next_key  (key_chain[i+1])
      );
    end
    else
    begin : g_last
      // last schedule step only feeds the final round.
      aes_key_round u_key (
        .clk       (clk),
        .key_in    (key_chain[i]),
        .rcon      (aes_tables_pkg::RCON[i]),
        .round_key (rkey[i]),
        .next_key  ()
      );
    end
  end

  for (genvar i = 0; i < `AES_ROUNDS - 1; i++)
  begin : g_round
    aes_mix_round u_round (
      .clk       (clk),
      .state_in  (st[i]),
      .round_key (rkey[i]),
      .state_out (st[i+1])
    );
  end

  aes_final_round u_final (
    .clk       (clk),
    .state_in  (st[`AES_ROUNDS-1]),
    .round_key (rkey[`AES_ROUNDS-1]),
    .state_out (out)
  );

  // strobe follows the block through the pipeline.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      valid_sr <= '0;
    end
    else
    begin
      valid_sr <= {valid_sr[`AES_LATENCY-2:0], in_valid};
    end
  end

  assign out_valid = valid_sr[`AES_LATENCY-1];

endmodule

/* design/cipher/aes_final_round.sv */
`timescale 1ns/100ps
`include "aes_defines.svh"

module aes_final_round (
  input  logic                  clk,
  input  aes_types_pkg::block_t state_in,
  input  aes_types_pkg::block_t round_key,
  output aes_types_pkg::block_t state_out
);

  localparam int NCOL = `AES_BLOCK_W / `AES_WORD_W;

  aes_types_pkg::column_u cols [NCOL];
  aes_types_pkg::column_u sub [NCOL];
  aes_types_pkg::column_u shifted [NCOL];
  aes_types_pkg::block_t  result;

  for (genvar c = 0; c < NCOL; c++)
  begin : g_col
    assign cols[c] = state_in[`AES_BLOCK_W-1-`AES_WORD_W*c -: `AES_WORD_W];

    aes_sbox_column u_sbox (
      .clk     (clk),
      .col_in  (cols[c]),
      .col_out (sub[c])
    );
  end

  // no mixcolumns here, only shiftrows and the last key.
  always_comb
  begin
    for (int c = 0; c < NCOL; c++)
    begin
      for (int r = 0; r < 4; r++)
      begin
        shifted[c].bytes[r] = sub[(c + r) % NCOL].bytes[r];
      end
      result[`AES_BLOCK_W-1-`AES_WORD_W*c -: `AES_WORD_W] =
        shifted[c].word ^ round_key[`AES_BLOCK_W-1-`AES_WORD_W*c -: `AES_WORD_W];
    end
  end

  always_ff @(posedge clk)
  begin
    state_out <= result;
  end

endmodule

/* design/cipher/aes_mix_round.sv */
`timescale 1ns/100ps
`include "aes_defines.svh"

module aes_mix_round (
  input  logic                  clk,
  input  aes_types_pkg::block_t state_in,
  input  aes_types_pkg::block_t round_key,
  output aes_types_pkg::block_t state_out
);

  localparam int NCOL = `AES_BLOCK_W / `AES_WORD_W;

  aes_types_pkg::column_u cols [NCOL];
  logic [`AES_WORD_W-1:0] t_q [NCOL][4];
  aes_types_pkg::block_t  mixed;

  // rotate a word right by n bytes.
  function automatic logic [`AES_WORD_W-1:0] ror_bytes(
    input logic [`AES_WORD_W-1:0] w,
    input int                     n
  );
    logic [2*`AES_WORD_W-1:0] d;
    d = {w, w} >> (8 * n);
    return d[`AES_WORD_W-1:0];
  endfunction

  for (genvar c = 0; c < NCOL; c++)
  begin : g_col
    assign cols[c] = state_in[`AES_BLOCK_W-1-`AES_WORD_W*c -: `AES_WORD_W];
  end

  // subbytes and mixcolumns in one table step.
  // row r needs {s, s, 3s, 2s} turned right by r+1 bytes.
  always_ff @(posedge clk)
  begin
    for (int c = 0; c < NCOL; c++)
    begin
      for (int r = 0; r < 4; r++)
      begin
        t_q[c][r] <= ror_bytes(aes_tables_pkg::t_entry(cols[c].bytes[r]), (r + 1) % 4);
      end
    end
  end

  // shiftrows picks row r of column c+r.
  always_comb
  begin
    for (int c = 0; c < NCOL; c++)
    begin
      mixed[`AES_BLOCK_W-1-`AES_WORD_W*c -: `AES_WORD_W] =
        t_q[c][0] ^
        t_q[(c + 1) % NCOL][1] ^
        t_q[(c + 2) % NCOL][2] ^
        t_q[(c + 3) % NCOL][3] ^
        round_key[`AES_BLOCK_W-1-`AES_WORD_W*c -: `AES_WORD_W];
    end
  end

  always_ff @(posedge clk)
  begin
    state_out <= mixed;
  end

endmodule

/* design/key_expand/aes_key_round.sv */
`timescale 1ns/100ps
`include "aes_defines.svh"

module aes_key_round (
  input  logic                  clk,
  input  aes_types_pkg::block_t key_in,
  input  aes_types_pkg::byte_t  rcon,
  output aes_types_pkg::block_t round_key,
  output aes_types_pkg::block_t next_key
);

  localparam int NWORD = `AES_BLOCK_W / `AES_WORD_W;

  logic [`AES_WORD_W-1:0] w [NWORD];
  logic [`AES_WORD_W-1:0] pre [NWORD];
  logic [`AES_WORD_W-1:0] pre_q [NWORD];
  aes_types_pkg::column_u rot_word;
  aes_types_pkg::column_u sub_word;

  for (genvar i = 0; i < NWORD; i++)
  begin : g_word
    assign w[i] = key_in[`AES_BLOCK_W-1-`AES_WORD_W*i -: `AES_WORD_W];
  end

  // prefix xor of the words, rcon folded into word 0.
  always_comb
  begin
    pre[0] = {w[0][`AES_WORD_W-1 -: 8] ^ rcon, w[0][`AES_WORD_W-9:0]};
    for (int i = 1; i < NWORD; i++)
    begin
      pre[i] = pre[i-1] ^ w[i];
    end
  end

  always_ff @(posedge clk)
  begin
    for (int i = 0; i < NWORD; i++)
    begin
      pre_q[i] <= pre[i];
    end
  end

  // rotword of the last word, substituted alongside the prefix register.
  assign rot_word = {w[NWORD-1][`AES_WORD_W-9:0], w[NWORD-1][`AES_WORD_W-1 -: 8]};

  aes_sbox_column u_sbox (
    .clk     (clk),
    .col_in  (rot_word),
    .col_out (sub_word)
  );

  always_comb
  begin
    for (int i = 0; i < NWORD; i++)
    begin
      round_key[`AES_BLOCK_W-1-`AES_WORD_W*i -: `AES_WORD_W] = pre_q[i] ^ sub_word.word;
    end
  end

  // second stage lines the key up with the next cipher round.
  always_ff @(posedge clk)
  begin
    next_key <= round_key;
  end

endmodule

/* design/aes_sbox_column.sv */
`timescale 1ns/100ps

module aes_sbox_column (
  input  logic                   clk,
  input  aes_types_pkg::column_u col_in,
  output aes_types_pkg::column_u col_out
);

  // one registered lookup per row byte.
  always_ff @(posedge clk)
  begin
    for (int r = 0; r < 4; r++)
    begin
      col_out.bytes[r] <= aes_tables_pkg::SBOX[col_in.bytes[r]];
    end
  end

endmodule

/* common/aes_tables_pkg.sv */
`include "aes_defines.svh"

package aes_tables_pkg;

  // forward s-box, indexed by the input byte.
  parameter aes_types_pkg::byte_t SBOX [256] = '{
    8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
    8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
    8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
    8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
    8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
    8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
    8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
    8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
    8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
    8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
    8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
    8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
    8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
    8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
    8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
    8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
    8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
    8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
    8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
    8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
    8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
    8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
    8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
    8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
    8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
    8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
    8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
    8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
    8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
    8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
    8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
    8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
  };

  parameter aes_types_pkg::byte_t RCON [`AES_ROUNDS] = '{
    8'h01, 8'h02, 8'h04, 8'h08, 8'h10, 8'h20, 8'h40, 8'h80, 8'h1b, 8'h36
  };

  // multiply by two modulo x^8 + x^4 + x^3 + x + 1.
  function automatic aes_types_pkg::byte_t xtime(input aes_types_pkg::byte_t b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
  endfunction

  // {s, s, 3s, 2s}; rotating it by the byte's row gives that row's mix column term.
  function automatic logic [`AES_WORD_W-1:0] t_entry(input aes_types_pkg::byte_t b);
    aes_types_pkg::byte_t s;
    aes_types_pkg::byte_t s2;
    s  = SBOX[b];
    s2 = xtime(s);
    return {s, s, s ^ s2, s2};
  endfunction

endpackage

/* common/aes_types_pkg.sv */
`include "aes_defines.svh"

package aes_types_pkg;

  // one state block or one round key.
  typedef logic [`AES_BLOCK_W-1:0] block_t;

  typedef logic [7:0] byte_t;

  // a state column, seen as a whole word or as its four row bytes.
  // bytes[0] is the most significant byte and holds row 0.
  typedef union packed {
    logic [`AES_WORD_W-1:0] word;
    byte_t [0:3]            bytes;
  } column_u;

endpackage

/* common/aes_defines.svh */
`ifndef AES_DEFINES_SVH
`define AES_DEFINES_SVH

// width of one state block and of the cipher key.
`define AES_BLOCK_W 128

// width of one state column.
`define AES_WORD_W 32

// number of cipher rounds for a 128-bit key.
`define AES_ROUNDS 10

// input stage plus two cycles per round.
`define AES_LATENCY 21

`endif
